// File: filelist.f
rvv_dispatch_pkg.sv
rvv_v0_mask_buffer.sv
rvv_dispatch_uop_latch.sv
rvv_dispatch_opr_byte_type.sv
rvv_dispatch_byte_type_out.sv
rvv_dispatch_top.sv
tb_rvv_dispatch.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the dispatch testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f filelist.f --top-module tb_rvv_dispatch -o sim \
    || { echo "build failed"; exit 1; }
result=$(./obj_dir/sim)
echo "$result"
echo "$result" | grep -qx "TB PASSED" && exit 0 || exit 1

// File: rvv_dispatch_byte_type_out.sv
// ------------------------------------------------------------------
// byte type output register: holds the tags, vd write strobe and the
// no-active flag for the retire side
// ------------------------------------------------------------------

`timescale 1ns/1ps

module rvv_dispatch_byte_type_out (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             in_valid,
    input  rvv_dispatch_pkg::opr_byte_type_t operand_byte_type,
    output logic                             out_valid,
    output rvv_dispatch_pkg::dispatch_out_t  dispatch_out
);

    logic [rvv_dispatch_pkg::VLENB-1:0] vd_strobe;

    // only active body bytes of vd may be written
    always_comb begin
        for (int i = 0; i < rvv_dispatch_pkg::VLENB; i++) begin
            vd_strobe[i] = (operand_byte_type.vd[i] == rvv_dispatch_pkg::BODY_ACTIVE);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            dispatch_out.byte_type <= operand_byte_type;
            dispatch_out.vd_strobe <= vd_strobe;
            dispatch_out.no_active <= ~|vd_strobe;   // nothing to write back
        end
    end

    // every output pulse traces back to one input pulse a cycle before,
    // and the payload register it presents was loaded with a known uop
    a_out_follows_in: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid |-> $past(in_valid) && !$isunknown(dispatch_out)
    ) else $error("out_valid without a loaded uop from the previous cycle");

endmodule

// File: rvv_dispatch_opr_byte_type.sv
// ------------------------------------------------------------------
// operand byte type: tags each byte of vs1, vs2 and vd as prestart,
// body-inactive, body-active or tail, purely combinational
// ------------------------------------------------------------------

`timescale 1ns/1ps

module rvv_dispatch_opr_byte_type (
    input  rvv_dispatch_pkg::uop_info_t        uop_info,
    input  logic [rvv_dispatch_pkg::VLEN-1:0]   v0_enable,
    output rvv_dispatch_pkg::opr_byte_type_t   operand_byte_type
);

    // log2 of bytes per element
    function automatic logic [1:0] eew_shift(input rvv_dispatch_pkg::eew_t eew);
        case (eew)
            rvv_dispatch_pkg::EEW16: eew_shift = 2'd1;
            rvv_dispatch_pkg::EEW32: eew_shift = 2'd2;
            default:                 eew_shift = 2'd0;
        endcase
    endfunction

    // type of one byte, given the operand start element and shift
    function automatic rvv_dispatch_pkg::byte_type_t classify(
        input logic [rvv_dispatch_pkg::VL_WIDTH-1:0] start,
        input logic [1:0]                            shift,
        input int                                    byte_idx,
        input rvv_dispatch_pkg::uop_info_t           uop,
        input logic [rvv_dispatch_pkg::VLEN-1:0]     v0
    );
        logic [rvv_dispatch_pkg::VLENB_WIDTH-1:0] offset;
        logic [rvv_dispatch_pkg::VL_WIDTH-1:0]    ele_index;
        logic                                     mask_bit;

        offset    = byte_idx[rvv_dispatch_pkg::VLENB_WIDTH-1:0] >> shift; // element within uop
        ele_index = start + {{(rvv_dispatch_pkg::VL_WIDTH - rvv_dispatch_pkg::VLENB_WIDTH){1'b0}},
                             offset};
        // index never exceeds 127, top bit only matters against vl
        mask_bit  = uop.vm ? v0[ele_index[rvv_dispatch_pkg::VL_WIDTH-2:0]] : 1'b1;

        if (ele_index >= uop.vl) begin
            classify = rvv_dispatch_pkg::TAIL;
        end else if (ele_index < {1'b0, uop.vstart}) begin
            classify = rvv_dispatch_pkg::NOT_CHANGE;   // prestart
        end else begin
            classify = mask_bit ? rvv_dispatch_pkg::BODY_ACTIVE
                                : rvv_dispatch_pkg::BODY_INACTIVE;
        end
    endfunction

    logic [1:0]                            vs1_shift;
    logic [1:0]                            vs2_shift;
    logic [1:0]                            vd_shift;
    logic [rvv_dispatch_pkg::VL_WIDTH-1:0] uop_index_ext;
    logic [rvv_dispatch_pkg::VL_WIDTH-1:0] vs1_start;
    logic [rvv_dispatch_pkg::VL_WIDTH-1:0] vs2_start;
    logic [rvv_dispatch_pkg::VL_WIDTH-1:0] vd_start;

    assign vs1_shift = eew_shift(uop_info.vs1_eew);
    assign vs2_shift = eew_shift(uop_info.vs2_eew);
    assign vd_shift  = eew_shift(uop_info.vd_eew);

    assign uop_index_ext = {{(rvv_dispatch_pkg::VL_WIDTH - rvv_dispatch_pkg::UOP_INDEX_WIDTH){1'b0}},
                            uop_info.uop_index};

    // uop_index * elements per register
    assign vs1_start = uop_index_ext << (rvv_dispatch_pkg::VLENB_WIDTH - vs1_shift);
    assign vs2_start = uop_index_ext << (rvv_dispatch_pkg::VLENB_WIDTH - vs2_shift);
    assign vd_start  = uop_index_ext << (rvv_dispatch_pkg::VLENB_WIDTH - vd_shift);

    genvar i;

    for (i = 0; i < rvv_dispatch_pkg::VLENB; i++) begin : gen_vs1_byte_type
        assign operand_byte_type.vs1[i] = classify(vs1_start, vs1_shift, i, uop_info, v0_enable);
    end

    for (i = 0; i < rvv_dispatch_pkg::VLENB; i++) begin : gen_vs2_byte_type
        assign operand_byte_type.vs2[i] = classify(vs2_start, vs2_shift, i, uop_info, v0_enable);
    end

    for (i = 0; i < rvv_dispatch_pkg::VLENB; i++) begin : gen_vd_byte_type
        assign operand_byte_type.vd[i] = classify(vd_start, vd_shift, i, uop_info, v0_enable);
    end

endmodule

// File: rvv_dispatch_pkg.sv
// ------------------------------------------------------------------
// dispatch package: widths, EEW and byte type encodings, and the
// structs for uop info and per-operand byte types
// ------------------------------------------------------------------

package rvv_dispatch_pkg;

    // vector register geometry
    localparam int VLEN            = 128;
    localparam int VLENB           = 16;             // bytes per register
    localparam int VLENB_WIDTH     = 4;              // byte index width
    localparam int VL_WIDTH        = 8;              // vl reaches 128
    localparam int VSTART_WIDTH    = 7;
    localparam int UOP_INDEX_WIDTH = 3;

    // effective element width of one operand
    typedef enum logic [1:0] {
        EEW8    = 2'd0,
        EEW16   = 2'd1,
        EEW32   = 2'd2,
        EEW_RSV = 2'd3   // not legal on a uop
    } eew_t;

    // what a later stage may do with one register byte
    typedef enum logic [1:0] {
        NOT_CHANGE    = 2'd0,   // prestart, below vstart
        BODY_INACTIVE = 2'd1,   // masked off
        BODY_ACTIVE   = 2'd2,
        TAIL          = 2'd3    // element index >= vl
    } byte_type_t;

    // uop as it arrives at dispatch
    typedef struct packed {
        eew_t                       vs1_eew;
        eew_t                       vs2_eew;
        eew_t                       vd_eew;
        logic                       vm;          // 1 = use v0 as mask
        logic [UOP_INDEX_WIDTH-1:0] uop_index;
        logic [VL_WIDTH-1:0]        vl;
        logic [VSTART_WIDTH-1:0]    vstart;
    } uop_info_t;

    // one type per byte, for each operand
    typedef struct packed {
        byte_type_t [VLENB-1:0] vs1;
        byte_type_t [VLENB-1:0] vs2;
        byte_type_t [VLENB-1:0] vd;
    } opr_byte_type_t;

    // registered result of the dispatch slice
    typedef struct packed {
        opr_byte_type_t   byte_type;
        logic [VLENB-1:0] vd_strobe;   // vd bytes that get written
        logic             no_active;   // uop has no active vd byte
    } dispatch_out_t;

endpackage

// File: rvv_dispatch_top.sv
// ------------------------------------------------------------------
// dispatch slice top: v0 buffer, uop latch, byte typing, output reg
// ------------------------------------------------------------------

`timescale 1ns/1ps

module rvv_dispatch_top (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              uop_valid,
    input  rvv_dispatch_pkg::uop_info_t       uop_info,
    input  logic                              v0_we,
    input  logic [rvv_dispatch_pkg::VLEN-1:0] v0_data,
    output logic                              out_valid,
    output rvv_dispatch_pkg::dispatch_out_t   dispatch_out
);

    logic [rvv_dispatch_pkg::VLEN-1:0] v0_enable;
    rvv_dispatch_pkg::uop_info_t       uop_q;
    logic                              uop_q_valid;
    rvv_dispatch_pkg::opr_byte_type_t  opr_byte_type;   // comb, into output reg

    rvv_v0_mask_buffer u_v0_buf (
        .clk       (clk),
        .rst_n     (rst_n),
        .v0_we     (v0_we),
        .v0_data   (v0_data),
        .v0_enable (v0_enable)
    );

    rvv_dispatch_uop_latch u_uop_latch (
        .clk         (clk),
        .rst_n       (rst_n),
        .uop_valid   (uop_valid),
        .uop_info    (uop_info),
        .uop_q       (uop_q),
        .uop_q_valid (uop_q_valid)
    );

    rvv_dispatch_opr_byte_type u_byte_type (
        .uop_info          (uop_q),
        .v0_enable         (v0_enable),
        .operand_byte_type (opr_byte_type)
    );

    rvv_dispatch_byte_type_out u_out (
        .clk               (clk),
        .rst_n             (rst_n),
        .in_valid          (uop_q_valid),
        .operand_byte_type (opr_byte_type),
        .out_valid         (out_valid),
        .dispatch_out      (dispatch_out)
    );

endmodule

// File: rvv_dispatch_uop_latch.sv
// ------------------------------------------------------------------
// uop latch: captures uop info on uop_valid, one cycle of latency
// ------------------------------------------------------------------

`timescale 1ns/1ps

module rvv_dispatch_uop_latch (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        uop_valid,
    input  rvv_dispatch_pkg::uop_info_t uop_info,
    output rvv_dispatch_pkg::uop_info_t uop_q,
    output logic                        uop_q_valid
);

    // valid lasts exactly one cycle per accepted uop
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            uop_q_valid <= 1'b0;
        end else begin
            uop_q_valid <= uop_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (uop_valid) begin
            uop_q <= uop_info;   // payload, held until next uop
        end
    end

    // reserved EEW would make the element index math meaningless
    a_eew_legal: assert property (
        @(posedge clk) disable iff (!rst_n)
        uop_valid |-> (uop_info.vs1_eew != rvv_dispatch_pkg::EEW_RSV) &&
                      (uop_info.vs2_eew != rvv_dispatch_pkg::EEW_RSV) &&
                      (uop_info.vd_eew  != rvv_dispatch_pkg::EEW_RSV)
    ) else $error("reserved EEW on incoming uop");

    // prestart region cannot run past vl
    a_vstart_le_vl: assert property (
        @(posedge clk) disable iff (!rst_n)
        uop_valid |-> ({1'b0, uop_info.vstart} <= uop_info.vl)
    ) else $error("vstart greater than vl on incoming uop");

endmodule

// File: rvv_v0_mask_buffer.sv
// ------------------------------------------------------------------
// v0 mask buffer: local copy of the v0 register, written on strobe
// ------------------------------------------------------------------

`timescale 1ns/1ps

module rvv_v0_mask_buffer (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           v0_we,
    input  logic [rvv_dispatch_pkg::VLEN-1:0] v0_data,
    output logic [rvv_dispatch_pkg::VLEN-1:0] v0_enable
);

    logic [rvv_dispatch_pkg::VLEN-1:0] v0_q;

    // all zeros after reset, so an early masked uop sees no active element
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            v0_q <= '0;
        end else if (v0_we) begin
            v0_q <= v0_data;
        end
    end

    // registered value goes straight to the byte-type logic
    assign v0_enable = v0_q;

    // an unknown mask bit would spread into every byte type downstream
    a_v0_data_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        v0_we |-> !$isunknown(v0_data)
    ) else $error("v0_data has unknown bits on write");

endmodule

// File: tb_rvv_dispatch.sv
// ----------------------------------------------------------------------
// testbench for the dispatch slice: table of uops applied in a loop,
// results checked against a byte-type reference model
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module tb_rvv_dispatch;

    typedef struct packed {
        rvv_dispatch_pkg::uop_info_t uop;
        logic                        v0_we;   // write v0 in the uop's own cycle
        logic [127:0]                v0;
        logic                        b2b;     // next entry follows on the very next cycle
    } stim_t;

    logic                              clk;
    logic                              rst_n;
    logic                              uop_valid;
    rvv_dispatch_pkg::uop_info_t       uop_info;
    logic                              v0_we;
    logic [rvv_dispatch_pkg::VLEN-1:0] v0_data;
    logic                              out_valid;
    rvv_dispatch_pkg::dispatch_out_t   dispatch_out;

    stim_t                           tab [0:15];
    rvv_dispatch_pkg::dispatch_out_t exp_tab [0:15];
    logic [127:0]                    model_v0;   // v0 as the model sees it
    int                              seed;
    int                              cyc;
    int                              value_errors;
    int                              protocol_errors;
    int                              idx_q[$];   // outstanding uops, oldest first
    int                              issue_q[$];
    int                              chk_idx;
    int                              chk_issue;

    rvv_dispatch_top dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .uop_valid    (uop_valid),
        .uop_info     (uop_info),
        .v0_we        (v0_we),
        .v0_data      (v0_data),
        .out_valid    (out_valid),
        .dispatch_out (dispatch_out)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    // one register byte, straight from the element index rules
    function automatic rvv_dispatch_pkg::byte_type_t byte_type_model(
        input rvv_dispatch_pkg::uop_info_t u,
        input rvv_dispatch_pkg::eew_t      eew,
        input int                          b,
        input logic [127:0]                v0
    );
        int bpe;
        int ele;
        case (eew)
            rvv_dispatch_pkg::EEW16: bpe = 2;
            rvv_dispatch_pkg::EEW32: bpe = 4;
            default:                 bpe = 1;
        endcase
        ele = int'(u.uop_index) * (rvv_dispatch_pkg::VLENB / bpe) + b / bpe;
        if (ele >= int'(u.vl))
            return rvv_dispatch_pkg::TAIL;
        else if (ele < int'(u.vstart))
            return rvv_dispatch_pkg::NOT_CHANGE;
        else if (u.vm && !v0[ele])
            return rvv_dispatch_pkg::BODY_INACTIVE;
        return rvv_dispatch_pkg::BODY_ACTIVE;
    endfunction

    function automatic rvv_dispatch_pkg::dispatch_out_t dispatch_model(
        input rvv_dispatch_pkg::uop_info_t u,
        input logic [127:0]                v0
    );
        rvv_dispatch_pkg::dispatch_out_t r;
        r = '0;
        for (int b = 0; b < rvv_dispatch_pkg::VLENB; b++) begin
            r.byte_type.vs1[b] = byte_type_model(u, u.vs1_eew, b, v0);
            r.byte_type.vs2[b] = byte_type_model(u, u.vs2_eew, b, v0);
            r.byte_type.vd[b]  = byte_type_model(u, u.vd_eew, b, v0);
            r.vd_strobe[b]     = (r.byte_type.vd[b] == rvv_dispatch_pkg::BODY_ACTIVE);
        end
        r.no_active = (r.vd_strobe == '0);
        return r;
    endfunction

    function automatic logic [127:0] random_v0();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    task automatic add_entry(
        input int idx,
        input rvv_dispatch_pkg::eew_t e1, input rvv_dispatch_pkg::eew_t e2,
        input rvv_dispatch_pkg::eew_t ed,
        input logic vm, input int uidx, input int vl, input int vstart,
        input logic wr, input logic [127:0] v0, input logic b2b
    );
        tab[idx].uop.vs1_eew   = e1;
        tab[idx].uop.vs2_eew   = e2;
        tab[idx].uop.vd_eew    = ed;
        tab[idx].uop.vm        = vm;
        tab[idx].uop.uop_index = uidx[2:0];
        tab[idx].uop.vl        = vl[7:0];
        tab[idx].uop.vstart    = vstart[6:0];
        tab[idx].v0_we         = wr;
        tab[idx].v0            = v0;
        tab[idx].b2b           = b2b;
        if (wr)
            model_v0 = v0;   // new v0 already seen by this uop
        exp_tab[idx] = dispatch_model(tab[idx].uop, model_v0);
    endtask

    task automatic compare_field(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
        assert (exp == got) else begin
            value_errors++;
            $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic fill_table();
        model_v0 = '0;
        // plain vl boundary, uop 0 and 1
        add_entry(0, rvv_dispatch_pkg::EEW8, rvv_dispatch_pkg::EEW8, rvv_dispatch_pkg::EEW8,
                  1'b0, 0, 10, 0, 1'b0, '0, 1'b0);
        add_entry(1, rvv_dispatch_pkg::EEW8, rvv_dispatch_pkg::EEW8, rvv_dispatch_pkg::EEW8,
                  1'b0, 1, 20, 0, 1'b0, '0, 1'b0);
        // masked by random v0
        add_entry(2, rvv_dispatch_pkg::EEW8, rvv_dispatch_pkg::EEW8, rvv_dispatch_pkg::EEW8,
                  1'b1, 0, 16, 0, 1'b1, random_v0(), 1'b0);
        add_entry(3, rvv_dispatch_pkg::EEW8, rvv_dispatch_pkg::EEW8, rvv_dispatch_pkg::EEW8,
                  1'b1, 2, 45, 0, 1'b0, '0, 1'b0);
        add_entry(4, rvv_dispatch_pkg::EEW16, rvv_dispatch_pkg::EEW32, rvv_dispatch_pkg::EEW8,
                  1'b1, 1, 30, 0, 1'b1, random_v0(), 1'b0);
        // prestart region
        add_entry(5, rvv_dispatch_pkg::EEW8, rvv_dispatch_pkg::EEW8, rvv_dispatch_pkg::EEW8,
                  1'b0, 0, 12, 5, 1'b0, '0, 1'b0);
        add_entry(6, rvv_dispatch_pkg::EEW8, rvv_dispatch_pkg::EEW32, rvv_dispatch_pkg::EEW16,
                  1'b1, 2, 40, 20, 1'b0, '0, 1'b0);
        add_entry(7, rvv_dispatch_pkg::EEW32, rvv_dispatch_pkg::EEW8, rvv_dispatch_pkg::EEW16,
                  1'b0, 3, 15, 0, 1'b0, '0, 1'b0);
        // empty uops
        add_entry(8, rvv_dispatch_pkg::EEW8, rvv_dispatch_pkg::EEW16, rvv_dispatch_pkg::EEW32,
                  1'b0, 0, 0, 0, 1'b0, '0, 1'b0);
        add_entry(9, rvv_dispatch_pkg::EEW8, rvv_dispatch_pkg::EEW8, rvv_dispatch_pkg::EEW8,
                  1'b1, 0, 16, 0, 1'b1, '0, 1'b0);
        // back to back, each with its own v0 write
        add_entry(10, rvv_dispatch_pkg::EEW8, rvv_dispatch_pkg::EEW8, rvv_dispatch_pkg::EEW8,
                  1'b1, 0, 16, 0, 1'b1, random_v0(), 1'b1);
        add_entry(11, rvv_dispatch_pkg::EEW8, rvv_dispatch_pkg::EEW8, rvv_dispatch_pkg::EEW8,
                  1'b1, 1, 32, 3, 1'b1, random_v0(), 1'b1);
        add_entry(12, rvv_dispatch_pkg::EEW16, rvv_dispatch_pkg::EEW16, rvv_dispatch_pkg::EEW16,
                  1'b1, 1, 14, 0, 1'b0, '0, 1'b0);
        // top of the register group
        add_entry(13, rvv_dispatch_pkg::EEW8, rvv_dispatch_pkg::EEW8, rvv_dispatch_pkg::EEW8,
                  1'b1, 7, 128, 0, 1'b0, '0, 1'b0);
        add_entry(14, rvv_dispatch_pkg::EEW8, rvv_dispatch_pkg::EEW8, rvv_dispatch_pkg::EEW8,
                  1'b1, 7, 125, 120, 1'b1, random_v0(), 1'b0);
        add_entry(15, rvv_dispatch_pkg::EEW32, rvv_dispatch_pkg::EEW32, rvv_dispatch_pkg::EEW16,
                  1'b0, 7, 128, 0, 1'b0, '0, 1'b0);
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (rst_n && out_valid) begin
            assert (idx_q.size() != 0) else begin
                protocol_errors++;
                $display("out_valid pulse at %0t with no uop outstanding", $time);
            end
            if (idx_q.size() != 0) begin
                chk_idx   = idx_q.pop_front();
                chk_issue = issue_q.pop_front();
                compare_field("latency", 2, cyc - chk_issue);
                compare_field("dispatch_out.byte_type.vs1",
                              exp_tab[chk_idx].byte_type.vs1, dispatch_out.byte_type.vs1);
                compare_field("dispatch_out.byte_type.vs2",
                              exp_tab[chk_idx].byte_type.vs2, dispatch_out.byte_type.vs2);
                compare_field("dispatch_out.byte_type.vd",
                              exp_tab[chk_idx].byte_type.vd, dispatch_out.byte_type.vd);
                compare_field("dispatch_out.vd_strobe", {16'd0, exp_tab[chk_idx].vd_strobe},
                              {16'd0, dispatch_out.vd_strobe});
                compare_field("dispatch_out.no_active", {31'd0, exp_tab[chk_idx].no_active},
                              {31'd0, dispatch_out.no_active});
            end
        end
    end

    // generous bound per entry plus reset
    initial begin
        repeat ($size(tab) * 10 + 50) @(posedge clk);
        $display("watchdog expired before all uops came out");
        $display("TB FAILED");
        $finish;
    end

    initial begin
        rst_n           = 1'b0;
        uop_valid       = 1'b0;
        uop_info        = '0;
        v0_we           = 1'b0;
        v0_data         = '0;
        value_errors    = 0;
        protocol_errors = 0;
        seed            = 32'h8ecf;
        fill_table();

        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;

        for (int i = 0; i < $size(tab); i++) begin
            @(posedge clk);
            #1;
            uop_valid = 1'b1;
            uop_info  = tab[i].uop;
            v0_we     = tab[i].v0_we;
            v0_data   = tab[i].v0;
            idx_q.push_back(i);
            issue_q.push_back(cyc);
            if (!tab[i].b2b) begin
                @(posedge clk);
                #1;
                uop_valid = 1'b0;
                v0_we     = 1'b0;
                while (idx_q.size() != 0)
                    @(negedge clk);
            end
        end

        repeat (3) @(posedge clk);
        $display("summary: %0d value errors, %0d protocol errors",
                 value_errors, protocol_errors);
        if (value_errors + protocol_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
